// ==== files.f ====
+incdir+bench
hdl/debug_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/debug_dumper.sv
hdl/debugger.sv
bench/debugger_tb.sv

// ==== bench/debugger_tb_tasks.svh ====
// compare a DUT value with its expected value
task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        value_errors++;
    end
endtask

task automatic report_failure(input string what);
    $display("at %0t ns: %s", $time, what);
    other_errors++;
endtask

// one 8N1 character from o_tx, each bit sampled at its middle
task automatic receive_serial_byte(input logic first_of_line, output debug_pkg::byte_t value,
                                   output int start_cycle);
    int i;
    @(negedge clk_in);
    while (o_tx !== 1'b0) begin
        @(negedge clk_in);
    end
    start_cycle = cycle_count;
    if (first_of_line) begin
        lines_started++;
        check_value("o_dump_active", o_dump_active, 1'b1);
        if (start_cycle - active_rise_cycle > 4) begin
            report_failure("o_dump_active rose too long before the first start bit");
        end
    end
    repeat (TICKS_PER_BIT / 2) @(negedge clk_in);
    if (o_tx !== 1'b0) begin
        report_failure("start bit on o_tx did not last until its middle");
    end
    for (i = 0; i < 8; i++) begin
        repeat (TICKS_PER_BIT) @(negedge clk_in);
        value[i] = o_tx;
    end
    repeat (TICKS_PER_BIT) @(negedge clk_in);
    if (o_tx !== 1'b1) begin
        report_failure("stop bit on o_tx was low");
    end
endtask

// a data byte may itself be 0x0a, so the line length comes from the width
task automatic decode_line(output line_t line, output int line_start);
    debug_pkg::byte_t value;
    int start_cycle;
    int n;
    line = '0;
    for (n = 0; n <= NUM_BYTES; n++) begin
        receive_serial_byte(n == 0, value, start_cycle);
        if (n == 0) begin
            line_start = start_cycle;
        end
        line = {line[LINE_BITS-9:0], value};
    end
    // still in the middle of the newline's stop bit here
    check_value("o_dump_active", o_dump_active, 1'b1);
    n = 0;
    while (o_dump_active === 1'b1 && n < TICKS_PER_BIT + 4) begin
        @(negedge clk_in);
        n++;
    end
    if (o_dump_active !== 1'b0) begin
        report_failure("o_dump_active stayed high after the newline");
    end
endtask

// drive one character on i_rx, optionally with a low stop bit
task automatic send_serial_byte(input debug_pkg::byte_t value, input logic bad_stop);
    int i;
    @(negedge clk_in);
    i_rx = 1'b0;
    repeat (TICKS_PER_BIT) @(negedge clk_in);
    for (i = 0; i < 8; i++) begin
        i_rx = value[i];
        repeat (TICKS_PER_BIT) @(negedge clk_in);
        if (i == 3) begin
            check_value("o_command_busy", o_command_busy, 1'b1);
        end
    end
    i_rx = !bad_stop;
    repeat (TICKS_PER_BIT) @(negedge clk_in);
    i_rx = 1'b1;
endtask

// counters move on falling edges, so look at them on rising edges
task automatic wait_receive_outcome(input int total_before);
    int n;
    n = 0;
    while (valid_count + frame_error_count == total_before && n < 3 * TICKS_PER_BIT) begin
        @(posedge clk_in);
        n++;
    end
    if (valid_count + frame_error_count == total_before) begin
        report_failure("receiver gave neither a valid nor a frame error pulse");
    end
    repeat (2) @(posedge clk_in);
endtask

// ==== bench/debugger_tb.sv ====
`timescale 1ns/1ps

module debugger_tb;

    localparam int DIVIDER_TICKS = 1199;
    localparam int DATA_WIDTH = 24;
    localparam int TICKS_PER_BIT = 8;
    localparam int NUM_BYTES = DATA_WIDTH / 8;
    localparam int LINE_BITS = 8 * (NUM_BYTES + 1);
    localparam int NUM_DUMPS = 6;
    localparam int NUM_CMDS = 7;
    localparam int BAD_CMD_INDEX = 3;
    localparam int TIMEOUT_CYCLES = 2 * ((NUM_DUMPS + 4) * (DIVIDER_TICKS + 1)
                                         + NUM_CMDS * debug_pkg::FRAME_BITS * TICKS_PER_BIT);

    typedef logic [LINE_BITS-1:0] line_t;

    logic                  clk_in;
    logic                  reset;
    logic [DATA_WIDTH-1:0] i_data;
    logic                  i_rx;
    logic                  o_tx;
    logic                  o_dump_active;
    debug_pkg::byte_t      o_command;
    logic                  o_command_valid;
    logic                  o_command_busy;
    logic                  o_frame_error;

    integer                seed;
    int                    cycle_count = 0;
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    lines_started = 0;
    int                    valid_count = 0;
    int                    frame_error_count = 0;
    int                    active_rise_cycle = 0;
    logic                  prev_active = 1'b0;
    logic                  commands_done = 1'b0;
    logic [DATA_WIDTH-1:0] word_q[$];
    line_t                 line_q[$];
    int                    start_q[$];

    debugger #(
        .DIVIDER_TICKS(DIVIDER_TICKS),
        .DATA_WIDTH   (DATA_WIDTH),
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) dut0 (
        .clk_in         (clk_in),
        .reset          (reset),
        .i_data         (i_data),
        .i_rx           (i_rx),
        .o_tx           (o_tx),
        .o_dump_active  (o_dump_active),
        .o_command      (o_command),
        .o_command_valid(o_command_valid),
        .o_command_busy (o_command_busy),
        .o_frame_error  (o_frame_error)
    );

    `include "debugger_tb_tasks.svh"

    // bytes of the word from the top down, then the newline
    function automatic line_t expected_line(input logic [DATA_WIDTH-1:0] word);
        line_t line;
        int i;
        line = '0;
        for (i = NUM_BYTES - 1; i >= 0; i--) begin
            line = {line[LINE_BITS-9:0], word[8*i +: 8]};
        end
        line = {line[LINE_BITS-9:0], debug_pkg::NEWLINE_BYTE};
        return line;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_word();
        logic [DATA_WIDTH-1:0] word;
        int i;
        word = '0;
        for (i = 0; i < DATA_WIDTH; i += 32) begin
            word = {word, $random(seed)};
        end
        return word;
    endfunction

    task automatic check_reset_outputs();
        check_value("o_tx", o_tx, 1'b1);
        check_value("o_dump_active", o_dump_active, 1'b0);
        check_value("o_command_valid", o_command_valid, 1'b0);
        check_value("o_frame_error", o_frame_error, 1'b0);
        check_value("o_command", o_command, 8'h00);
    endtask

    always #20 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, dump lines or commands never finished",
                     cycle_count);
            $display("errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("Test failed");
            $finish;
        end
    end

    // pulse counters and the rising edge of o_dump_active
    always @(negedge clk_in) begin
        prev_active <= o_dump_active;
        if (o_dump_active === 1'b1 && prev_active === 1'b0) begin
            active_rise_cycle = cycle_count;
        end
        if (reset === 1'b0 && o_command_valid === 1'b1) begin
            valid_count++;
        end
        if (reset === 1'b0 && o_frame_error === 1'b1) begin
            frame_error_count++;
        end
    end

    initial begin : data_stimulus
        int k;
        seed = 32'h487dfea7;
        clk_in = 1'b0;
        reset = 1'b1;
        i_rx = 1'b1;
        i_data = random_word();
        word_q.push_back(i_data);
        repeat (5) begin
            @(negedge clk_in);
            check_reset_outputs();
        end
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk_in);
            check_reset_outputs();
        end
        // the first two lines share one word, after that a new word per line
        for (k = 1; k < NUM_DUMPS; k++) begin
            wait (lines_started >= k);
            @(negedge clk_in);
            if (k >= 2) begin
                i_data = random_word();
            end
            word_q.push_back(i_data);
        end
    end

    initial begin : line_decoder
        line_t line;
        int line_start;
        wait (reset === 1'b0);
        forever begin
            decode_line(line, line_start);
            line_q.push_back(line);
            start_q.push_back(line_start);
        end
    end

    // commands start while the first dump line is on o_tx
    initial begin : command_stimulus
        debug_pkg::byte_t value;
        debug_pkg::byte_t last_command;
        logic bad;
        int valid_before;
        int error_before;
        int c;
        last_command = 8'h00;
        wait (lines_started >= 1);
        for (c = 0; c < NUM_CMDS; c++) begin
            value = $random(seed);
            bad = (c == BAD_CMD_INDEX);
            valid_before = valid_count;
            error_before = frame_error_count;
            send_serial_byte(value, bad);
            wait_receive_outcome(valid_before + error_before);
            if (bad) begin
                check_value("o_frame_error pulses", frame_error_count, error_before + 1);
                check_value("o_command_valid pulses", valid_count, valid_before);
                check_value("o_command", o_command, last_command);
            end else begin
                check_value("o_command_valid pulses", valid_count, valid_before + 1);
                check_value("o_frame_error pulses", frame_error_count, error_before);
                check_value("o_command", o_command, value);
                last_command = value;
            end
            repeat (2 * TICKS_PER_BIT) @(negedge clk_in);
        end
        commands_done = 1'b1;
    end

    initial begin : line_compare
        line_t got;
        int start_cycle;
        int prev_start;
        int k;
        prev_start = 0;
        for (k = 0; k < NUM_DUMPS; k++) begin
            wait (line_q.size() > 0);
            got = line_q.pop_front();
            start_cycle = start_q.pop_front();
            check_value("o_tx line", got, expected_line(word_q[k]));
            if (k > 0) begin
                check_value("line start spacing", start_cycle - prev_start, DIVIDER_TICKS + 1);
            end
            prev_start = start_cycle;
        end
        wait (commands_done === 1'b1);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== hdl/debugger.sv ====
`timescale 1ns/1ps

module debugger #(
    parameter int DIVIDER_TICKS = 1199,
    parameter int DATA_WIDTH = 24,
    parameter int TICKS_PER_BIT = 8
) (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic [DATA_WIDTH-1:0] i_data,
    input  logic                  i_rx,
    output logic                  o_tx,
    output logic                  o_dump_active,
    output debug_pkg::byte_t      o_command,
    output logic                  o_command_valid,
    output logic                  o_command_busy,
    output logic                  o_frame_error
);

    // dumper to transmitter link
    logic             tx_start;
    debug_pkg::byte_t tx_byte;
    logic             tx_busy;

    debug_dumper #(
        .DIVIDER_TICKS(DIVIDER_TICKS),
        .DATA_WIDTH   (DATA_WIDTH)
    ) dumper0 (
        .clk_in       (clk_in),
        .reset        (reset),
        .i_data       (i_data),
        .i_tx_busy    (tx_busy),
        .o_tx_start   (tx_start),
        .o_tx_byte    (tx_byte),
        .o_dump_active(o_dump_active)
    );

    // done pulse has no user here, busy alone paces the dumper
    uart_tx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) uart_tx0 (
        .clk_in (clk_in),
        .reset  (reset),
        .i_start(tx_start),
        .i_data (tx_byte),
        .o_tx   (o_tx),
        .o_busy (tx_busy),
        .o_done ()
    );

    uart_rx #(
        .TICKS_PER_BIT(TICKS_PER_BIT)
    ) uart_rx0 (
        .clk_in       (clk_in),
        .reset        (reset),
        .i_rx         (i_rx),
        .o_data       (o_command),
        .o_valid      (o_command_valid),
        .o_busy       (o_command_busy),
        .o_frame_error(o_frame_error)
    );

endmodule

// ==== hdl/debug_dumper.sv ====
`timescale 1ns/1ps

module debug_dumper #(
    parameter int DIVIDER_TICKS = 1199,
    parameter int DATA_WIDTH = 24
) (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic [DATA_WIDTH-1:0] i_data,
    input  logic                  i_tx_busy,
    output logic                  o_tx_start,
    output debug_pkg::byte_t      o_tx_byte,
    output logic                  o_dump_active
);

    localparam int NUM_BYTES = DATA_WIDTH / 8;
    localparam int TIMER_W = (DIVIDER_TICKS > 0) ? $clog2(DIVIDER_TICKS + 1) : 1;
    localparam int POS_W = $clog2(NUM_BYTES + 1);

    typedef logic [TIMER_W-1:0] timer_t;
    // bytes still to send before the newline
    typedef logic [POS_W-1:0] byte_pos_t;

    timer_t                 timer_count;
    logic                   dump_tick;
    debug_pkg::dump_state_t state;
    byte_pos_t              byte_pos;
    logic                   capture;
    logic [DATA_WIDTH-1:0]  snapshot;

    // free-running dump period timer
    assign dump_tick = (timer_count == timer_t'(DIVIDER_TICKS));

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            timer_count <= '0;
        end else if (dump_tick) begin
            timer_count <= '0;
        end else begin
            timer_count <= timer_count + 1'b1;
        end
    end

    // strobes that arrive mid-line are simply lost
    assign capture = dump_tick && (state == debug_pkg::DUMP_IDLE);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state    <= debug_pkg::DUMP_IDLE;
            byte_pos <= '0;
        end else begin
            case (state)
                debug_pkg::DUMP_IDLE: begin
                    if (capture) begin
                        byte_pos <= byte_pos_t'(NUM_BYTES);
                        state    <= debug_pkg::DUMP_NEXT;
                    end
                end
                debug_pkg::DUMP_NEXT: begin
                    state <= debug_pkg::DUMP_SEND;
                end
                debug_pkg::DUMP_SEND: begin
                    if (!i_tx_busy) begin
                        state <= debug_pkg::DUMP_WAIT;
                    end
                end
                debug_pkg::DUMP_WAIT: begin
                    // busy is already up the cycle after the start strobe
                    if (!i_tx_busy) begin
                        if (byte_pos == '0) begin
                            state <= debug_pkg::DUMP_IDLE;
                        end else begin
                            byte_pos <= byte_pos - 1'b1;
                            state    <= debug_pkg::DUMP_NEXT;
                        end
                    end
                end
                default: begin
                    state <= debug_pkg::DUMP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (capture) begin
            snapshot <= i_data;
        end
        if (state == debug_pkg::DUMP_NEXT) begin
            // msb first, newline once the position runs out
            if (byte_pos == '0) begin
                o_tx_byte <= debug_pkg::NEWLINE_BYTE;
            end else begin
                o_tx_byte <= snapshot[8 * byte_pos - 1 -: 8];
            end
        end
    end

    // two cycles after the strobe when the transmitter is free
    assign o_tx_start = (state == debug_pkg::DUMP_SEND) && !i_tx_busy;
    assign o_dump_active = (state != debug_pkg::DUMP_IDLE);

    a_width_bytes: assert property (
        @(posedge clk_in) (DATA_WIDTH % 8) == 0
    ) else $error("debug_dumper: DATA_WIDTH %0d is not whole bytes", DATA_WIDTH);

    // DUMP_WAIT relies on the transmitter taking every strobe at once
    a_start_taken: assert property (
        @(posedge clk_in) disable iff (reset)
        o_tx_start |=> i_tx_busy
    ) else $error("debug_dumper: transmitter did not take the start strobe");

    a_start_single: assert property (
        @(posedge clk_in) disable iff (reset)
        o_tx_start |=> !o_tx_start
    ) else $error("debug_dumper: start strobe held for two cycles");

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
    parameter int TICKS_PER_BIT = 8
) (
    input  logic             clk_in,
    input  logic             reset,
    input  logic             i_rx,
    output debug_pkg::byte_t o_data,
    output logic             o_valid,
    output logic             o_busy,
    output logic             o_frame_error
);

    localparam int TICK_W = (TICKS_PER_BIT > 1) ? $clog2(TICKS_PER_BIT) : 1;
    localparam int INDEX_W = $clog2(debug_pkg::FRAME_BITS);
    localparam int HALF_TICKS = TICKS_PER_BIT / 2;

    typedef logic [TICK_W-1:0] tick_t;
    typedef logic [INDEX_W-1:0] bit_index_t;

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    tick_t            tick_count;
    bit_index_t       bit_index;
    logic             sample_now;
    logic             stop_bit;
    logic             data_bit;
    debug_pkg::byte_t shift_reg;

    // first sample half a bit after the edge, then one full bit apart
    assign sample_now = (bit_index == '0) ? (tick_count == tick_t'(HALF_TICKS - 1))
                                          : (tick_count == tick_t'(TICKS_PER_BIT - 1));
    assign stop_bit = (bit_index == bit_index_t'(debug_pkg::FRAME_BITS - 1));
    assign data_bit = o_busy && sample_now && (bit_index != '0) && !stop_bit;

    // two-flop synchronizer plus one more stage for edge detection
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            o_busy        <= 1'b0;
            o_valid       <= 1'b0;
            o_frame_error <= 1'b0;
            o_data        <= '0;
            tick_count    <= '0;
            bit_index     <= '0;
        end else begin
            o_valid       <= 1'b0;
            o_frame_error <= 1'b0;
            if (!o_busy) begin
                if (rx_prev && !rx_sync) begin
                    o_busy     <= 1'b1;
                    tick_count <= '0;
                    bit_index  <= '0;
                end
            end else if (sample_now) begin
                tick_count <= '0;
                if (bit_index == '0) begin
                    // start bit gone high again at mid-bit, treat as a glitch
                    if (rx_sync) begin
                        o_busy <= 1'b0;
                    end else begin
                        bit_index <= bit_index + 1'b1;
                    end
                end else if (stop_bit) begin
                    o_busy <= 1'b0;
                    if (rx_sync) begin
                        o_data  <= shift_reg;
                        o_valid <= 1'b1;
                    end else begin
                        o_frame_error <= 1'b1;
                    end
                end else begin
                    bit_index <= bit_index + 1'b1;
                end
            end else begin
                tick_count <= tick_count + 1'b1;
            end
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk_in) begin
        if (data_bit) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    a_one_outcome: assert property (
        @(posedge clk_in) disable iff (reset)
        !(o_valid && o_frame_error)
    ) else $error("uart_rx: valid and frame error in the same cycle");

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
    parameter int TICKS_PER_BIT = 8
) (
    input  logic             clk_in,
    input  logic             reset,
    input  logic             i_start,
    input  debug_pkg::byte_t i_data,
    output logic             o_tx,
    output logic             o_busy,
    output logic             o_done
);

    localparam int TICK_W = (TICKS_PER_BIT > 1) ? $clog2(TICKS_PER_BIT) : 1;
    localparam int INDEX_W = $clog2(debug_pkg::FRAME_BITS);

    typedef logic [TICK_W-1:0] tick_t;
    typedef logic [INDEX_W-1:0] bit_index_t;

    tick_t                           tick_count;
    bit_index_t                      bit_index;
    logic [debug_pkg::FRAME_BITS-1:0] frame;
    logic                            bit_end;

    assign bit_end = (tick_count == tick_t'(TICKS_PER_BIT - 1));

    // lsb of the frame is always the bit on the line, all ones when idle
    assign o_tx = frame[0];

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            frame      <= '1;
            o_busy     <= 1'b0;
            o_done     <= 1'b0;
            tick_count <= '0;
            bit_index  <= '0;
        end else begin
            o_done <= 1'b0;
            if (!o_busy) begin
                if (i_start) begin
                    // stop bit on top, start bit at the bottom
                    frame      <= {1'b1, i_data, 1'b0};
                    o_busy     <= 1'b1;
                    tick_count <= '0;
                    bit_index  <= '0;
                end
            end else if (bit_end) begin
                tick_count <= '0;
                if (bit_index == bit_index_t'(debug_pkg::FRAME_BITS - 1)) begin
                    // stop bit stays in frame[0], so the line rests high
                    o_busy <= 1'b0;
                    o_done <= 1'b1;
                end else begin
                    bit_index <= bit_index + 1'b1;
                    frame     <= {1'b1, frame[debug_pkg::FRAME_BITS-1:1]};
                end
            end else begin
                tick_count <= tick_count + 1'b1;
            end
        end
    end

    a_idle_high: assert property (
        @(posedge clk_in) disable iff (reset)
        !o_busy |-> o_tx
    ) else $error("uart_tx: line low while idle");

    a_start_idle: assert property (
        @(posedge clk_in) disable iff (reset)
        i_start |-> !o_busy
    ) else $error("uart_tx: start while busy, byte dropped");

endmodule

// ==== hdl/debug_pkg.sv ====
package debug_pkg;

    // one serial character, as it goes over the line
    typedef logic [7:0] byte_t;

    // dumper states, one line per strobe
    typedef enum logic [1:0] {
        // waiting for a strobe from the dump timer
        DUMP_IDLE,
        // pick the next byte of the snapshot, or the newline
        DUMP_NEXT,
        // hold the byte until the transmitter is free
        DUMP_SEND,
        // byte handed over, wait for it to leave
        DUMP_WAIT
    } dump_state_t;

    // terminates every dump line
    localparam byte_t NEWLINE_BYTE = 8'h0A;

    // start bit, 8 data bits, stop bit
    localparam int FRAME_BITS = 10;

endpackage
